//--- rtl/uc_credit_grant.sv
// credit demand calculation and the grant FSM that pays credits out toward the traffic manager
`timescale 1ns/1ps
`include "user_ctrl_params.svh"

module uc_credit_grant (
   input  logic                       axi_aclk,
   input  logic                       axi_aresetn,
   input  logic                       start_pls,
   input  user_ctrl_pkg::len_t        c2h_st_len,
   input  user_ctrl_pkg::pkt_cnt_t    c2h_num_pkt,
   input  user_ctrl_pkg::credit_t     crd_avail,
   input  logic                       crd_added,
   output user_ctrl_pkg::credit_t     credit_needed,
   output user_ctrl_pkg::credit_t     credit_perpkt_in,
   output user_ctrl_pkg::credit_t     credit_out,
   output logic                       credit_updt,
   output user_ctrl_pkg::credit_t     credit_sent,
   output logic                       grant_busy
);

   // fixed buffer size, one credit per buffer
   localparam user_ctrl_pkg::len_t BUF_BYTES = user_ctrl_pkg::len_t'(1 << `UC_BUF_SHIFT);
   localparam user_ctrl_pkg::len_t BUF_MASK  = BUF_BYTES - 1'b1;

   user_ctrl_pkg::crdt_state_e crdt_state;
   logic                       start_d1;
   user_ctrl_pkg::credit_t     perpkt_c;
   user_ctrl_pkg::credit_t     need_c;
   user_ctrl_pkg::credit_t     avail_eff;
   user_ctrl_pkg::credit_t     remain;
   user_ctrl_pkg::credit_t     grant_amt;
   logic                       grant_go;
   logic                       grant_last;

   //////////////////////////////
   // demand
   //////////////////////////////

   // ceil(len / buffer), short packets still take one buffer
   assign perpkt_c = (c2h_st_len <= BUF_BYTES) ? user_ctrl_pkg::credit_t'(1) :
                     user_ctrl_pkg::credit_t'(c2h_st_len >> `UC_BUF_SHIFT) +
                     user_ctrl_pkg::credit_t'(|(c2h_st_len & BUF_MASK));
   assign need_c   = perpkt_c * user_ctrl_pkg::credit_t'(c2h_num_pkt);

   always_ff @(posedge axi_aclk) begin
      if (!axi_aresetn) begin
         credit_needed    <= '0;
         credit_perpkt_in <= '0;
         start_d1         <= 1'b0;
      end else begin
         // demand is valid the cycle after the start pulse
         start_d1 <= start_pls;
         if (start_pls) begin
            credit_needed    <= need_c;
            credit_perpkt_in <= perpkt_c;
         end
      end
   end

   //////////////////////////////
   // grant FSM
   //////////////////////////////

   // crd_avail lags our own subtraction by a cycle so take it off here
   assign avail_eff = !credit_updt ? crd_avail :
                      (crd_avail > credit_out) ? crd_avail - credit_out : '0;
   assign remain    = credit_needed - credit_sent;
   // smaller of what is there and what is still owed
   assign grant_amt = (avail_eff < remain) ? avail_eff : remain;
   assign grant_last = (grant_amt == remain);

   // first grant right after start, later ones when credits arrive
   assign grant_go = (grant_amt != '0) &&
                     (((crdt_state == user_ctrl_pkg::CRDT_IDLE) && start_d1) ||
                      ((crdt_state == user_ctrl_pkg::CRDT_TFR) && crd_added));

   always_ff @(posedge axi_aclk) begin
      if (!axi_aresetn) begin
         crdt_state  <= user_ctrl_pkg::CRDT_IDLE;
         credit_updt <= 1'b0;
         credit_out  <= '0;
         credit_sent <= '0;
      end else begin
         credit_updt <= 1'b0;
         if (grant_go) begin
            credit_updt <= 1'b1;
            credit_out  <= grant_amt;
            credit_sent <= credit_sent + grant_amt;
         end
         case (crdt_state)
            user_ctrl_pkg::CRDT_IDLE: begin
               // zero demand or full cover ends at once
               if (start_d1) begin
                  crdt_state <= grant_last ? user_ctrl_pkg::CRDT_END : user_ctrl_pkg::CRDT_TFR;
               end
            end
            user_ctrl_pkg::CRDT_TFR: begin
               if (grant_go && grant_last) begin
                  crdt_state <= user_ctrl_pkg::CRDT_END;
               end
            end
            user_ctrl_pkg::CRDT_END: begin
               // transfer covered, clear the running sum
               credit_sent <= '0;
               crdt_state  <= user_ctrl_pkg::CRDT_IDLE;
            end
            default: crdt_state <= user_ctrl_pkg::CRDT_IDLE;
         endcase
      end
   end

   assign grant_busy = (crdt_state != user_ctrl_pkg::CRDT_IDLE);

endmodule

//--- rtl/uc_credit_table.sv
// per-queue credit table fed by traffic-manager descriptor status and drained by the grant FSM
`timescale 1ns/1ps
`include "user_ctrl_params.svh"

module uc_credit_table (
   input  logic                       axi_aclk,
   input  logic                       axi_aresetn,
   input  logic                       tm_dsc_sts_vld,
   input  logic                       tm_dsc_sts_qen,
   input  logic                       tm_dsc_sts_qinv,
   input  logic                       tm_dsc_sts_mm,
   input  logic                       tm_dsc_sts_dir,
   input  user_ctrl_pkg::qid_t        tm_dsc_sts_qid,
   input  user_ctrl_pkg::credit_t     tm_dsc_sts_avl,
   input  user_ctrl_pkg::qid_t        c2h_st_qid,
   input  logic                       credit_updt,
   input  user_ctrl_pkg::credit_t     credit_out,
   output logic                       tm_dsc_sts_rdy,
   output user_ctrl_pkg::credit_t     crd_avail,
   output logic                       crd_added
);

   localparam int DEPTH = 1 << `UC_QID_W;

   user_ctrl_pkg::credit_t crd_mem [DEPTH];
   // accepted update, one cycle late
   logic                   tm_acc;
   logic                   upd_d1;
   logic                   qinv_d1;
   user_ctrl_pkg::qid_t    qid_d1;
   user_ctrl_pkg::credit_t avl_d1;
   // single slot for an update pushed back by a grant
   logic                   hold_vld;
   logic                   hold_qinv;
   user_ctrl_pkg::qid_t    hold_qid;
   user_ctrl_pkg::credit_t hold_avl;
   // the update competing for the table this cycle
   logic                   tm_pend;
   logic                   tm_qinv;
   logic                   tm_wr;
   user_ctrl_pkg::qid_t    tm_qid;
   user_ctrl_pkg::credit_t tm_avl;
   user_ctrl_pkg::credit_t tm_val;
   user_ctrl_pkg::credit_t cur_val;
   user_ctrl_pkg::credit_t sub_val;

   // c2h streaming queues only, qinv beats pass so the entry can be cleared
   assign tm_acc = tm_dsc_sts_vld & tm_dsc_sts_rdy & tm_dsc_sts_dir & ~tm_dsc_sts_mm &
                   (tm_dsc_sts_qen | tm_dsc_sts_qinv);

   // held update is older so it goes first
   assign tm_pend = hold_vld | upd_d1;
   assign tm_qid  = hold_vld ? hold_qid : qid_d1;
   assign tm_avl  = hold_vld ? hold_avl : avl_d1;
   assign tm_qinv = hold_vld ? hold_qinv : qinv_d1;
   // the grant subtraction owns the write port when both want it
   assign tm_wr   = tm_pend & ~credit_updt;

   // stall the traffic manager while its update is being deferred
   assign tm_dsc_sts_rdy = ~(credit_updt & tm_pend);

   assign tm_val  = tm_qinv ? '0 : crd_mem[tm_qid] + tm_avl;
   assign cur_val = crd_mem[c2h_st_qid];
   // saturate in case a qinv zeroed the queue under a grant
   assign sub_val = (cur_val > credit_out) ? cur_val - credit_out : '0;

   always_ff @(posedge axi_aclk) begin
      qid_d1 <= tm_dsc_sts_qid;
      avl_d1 <= tm_dsc_sts_avl;
      qinv_d1 <= tm_dsc_sts_qinv;
      if (credit_updt && tm_pend) begin
         hold_qid  <= tm_qid;
         hold_avl  <= tm_avl;
         hold_qinv <= tm_qinv;
      end
   end

   always_ff @(posedge axi_aclk) begin
      if (!axi_aresetn) begin
         upd_d1    <= 1'b0;
         hold_vld  <= 1'b0;
         crd_avail <= '0;
         crd_added <= 1'b0;
         for (int i = 0; i < DEPTH; i++) begin
            crd_mem[i] <= '0;
         end
      end else begin
         upd_d1   <= tm_acc;
         hold_vld <= credit_updt & tm_pend;
         // pulse only for the queue being served
         crd_added <= tm_wr & (tm_qid == c2h_st_qid);
         if (credit_updt) begin
            crd_mem[c2h_st_qid] <= sub_val;
            crd_avail           <= sub_val;
         end else if (tm_pend) begin
            crd_mem[tm_qid] <= tm_val;
            crd_avail       <= (tm_qid == c2h_st_qid) ? tm_val : cur_val;
         end else begin
            crd_avail <= cur_val;
         end
      end
   end

endmodule

//--- rtl/uc_reg_file.sv
// axi-lite register file of the C2H credit manager with start pulse and drop/accept counters
`timescale 1ns/1ps
`include "user_ctrl_params.svh"

module uc_reg_file (
   input  logic                          axi_aclk,
   input  logic                          axi_aresetn,
   input  user_ctrl_pkg::axil_word_t     m_axil_awaddr,
   input  logic                          m_axil_wvalid,
   input  logic                          m_axil_wready,
   input  user_ctrl_pkg::axil_word_t     m_axil_wdata,
   input  user_ctrl_pkg::axil_word_t     m_axil_araddr,
   input  logic                          axis_c2h_drop,
   input  logic                          axis_c2h_drop_valid,
   input  logic                          grant_busy,
   input  user_ctrl_pkg::credit_t        credit_sent,
   output user_ctrl_pkg::axil_word_t     m_axil_rdata,
   output logic                          st_loopback,
   output user_ctrl_pkg::qid_t           c2h_st_qid,
   output user_ctrl_pkg::len_t           c2h_st_len,
   output user_ctrl_pkg::pkt_cnt_t       c2h_num_pkt,
   output logic                          start_pls
);

   logic                          wr_en;
   // start bit of the c2h control word, high for one cycle after the write
   logic                          ctrl_start;
   logic                          start_d1;
   user_ctrl_pkg::axil_word_t     scratch0;
   user_ctrl_pkg::axil_word_t     scratch1;
   logic [`UC_CNT_W-1:0]          drop_cnt;
   logic [`UC_CNT_W-1:0]          accept_cnt;

   // a beat is written when data is valid and accepted
   assign wr_en = m_axil_wvalid & m_axil_wready;

   //////////////////////////////
   // register writes
   //////////////////////////////

   always_ff @(posedge axi_aclk) begin
      if (!axi_aresetn) begin
         c2h_st_qid  <= user_ctrl_pkg::qid_t'(`UC_QID_RST);
         c2h_st_len  <= user_ctrl_pkg::len_t'(`UC_LEN_RST);
         c2h_num_pkt <= user_ctrl_pkg::pkt_cnt_t'(`UC_NUM_PKT_RST);
         st_loopback <= 1'b0;
         ctrl_start  <= 1'b0;
         scratch0    <= '0;
         scratch1    <= '0;
      end else begin
         // start self clears unless written again
         ctrl_start <= 1'b0;
         if (wr_en) begin
            case (m_axil_awaddr)
               user_ctrl_pkg::REG_QID:      c2h_st_qid  <= m_axil_wdata[`UC_QID_W-1:0];
               user_ctrl_pkg::REG_LEN:      c2h_st_len  <= m_axil_wdata[`UC_LEN_W-1:0];
               user_ctrl_pkg::REG_C2H_CTRL: begin
                  // bit 0 loopback, bit 1 start
                  st_loopback <= m_axil_wdata[0];
                  ctrl_start  <= m_axil_wdata[1];
               end
               user_ctrl_pkg::REG_NUM_PKT:  c2h_num_pkt <= m_axil_wdata[`UC_PKT_W-1:0];
               user_ctrl_pkg::REG_SCRATCH0: scratch0    <= m_axil_wdata;
               user_ctrl_pkg::REG_SCRATCH1: scratch1    <= m_axil_wdata;
               // status and counters are read only
               default: ;
            endcase
         end
      end
   end

   //////////////////////////////
   // start pulse
   //////////////////////////////

   always_ff @(posedge axi_aclk) begin
      if (!axi_aresetn) begin
         start_d1 <= 1'b0;
      end else begin
         start_d1 <= ctrl_start;
      end
   end

   // rising edge only, back to back start writes give one pulse
   assign start_pls = ctrl_start & ~start_d1;

   //////////////////////////////
   // drop and accept counters
   //////////////////////////////

   always_ff @(posedge axi_aclk) begin
      if (!axi_aresetn) begin
         drop_cnt   <= '0;
         accept_cnt <= '0;
      end else if (start_pls) begin
         // each transfer counts from zero
         drop_cnt   <= '0;
         accept_cnt <= '0;
      end else if (axis_c2h_drop_valid) begin
         if (axis_c2h_drop) begin
            drop_cnt <= drop_cnt + 1'b1;
         end else begin
            accept_cnt <= accept_cnt + 1'b1;
         end
      end
   end

   //////////////////////////////
   // read mux
   //////////////////////////////

   // combinational from araddr, unmapped offsets return zero
   always_comb begin
      m_axil_rdata = '0;
      case (m_axil_araddr)
         user_ctrl_pkg::REG_QID:        m_axil_rdata[`UC_QID_W-1:0] = c2h_st_qid;
         user_ctrl_pkg::REG_LEN:        m_axil_rdata[`UC_LEN_W-1:0] = c2h_st_len;
         user_ctrl_pkg::REG_C2H_CTRL:   m_axil_rdata[1:0] = {ctrl_start, st_loopback};
         user_ctrl_pkg::REG_GRANT_STS: begin
            // busy flag on top, running grant sum below
            m_axil_rdata[`UC_AXIL_W-1]   = grant_busy;
            m_axil_rdata[`UC_CRD_W-1:0] = credit_sent;
         end
         user_ctrl_pkg::REG_NUM_PKT:    m_axil_rdata[`UC_PKT_W-1:0] = c2h_num_pkt;
         user_ctrl_pkg::REG_SCRATCH0:   m_axil_rdata = scratch0;
         user_ctrl_pkg::REG_SCRATCH1:   m_axil_rdata = scratch1;
         user_ctrl_pkg::REG_DROP_CNT:   m_axil_rdata[`UC_CNT_W-1:0] = drop_cnt;
         user_ctrl_pkg::REG_ACCEPT_CNT: m_axil_rdata[`UC_CNT_W-1:0] = accept_cnt;
         default:                       m_axil_rdata = '0;
      endcase
   end

endmodule

//--- rtl/user_ctrl_params.svh
// width, reset and buffer constants of the C2H credit manager, included wherever a size is needed
`ifndef USER_CTRL_PARAMS_SVH
`define USER_CTRL_PARAMS_SVH

//////////////////////////////
// bus and field widths
//////////////////////////////

// axi-lite data and address width
`define UC_AXIL_W 32
// queue id width, table depth is 2**UC_QID_W
`define UC_QID_W 6
// credit count width, one credit per descriptor
`define UC_CRD_W 16
// transfer length in bytes
`define UC_LEN_W 16
// packets per transfer
`define UC_PKT_W 11
// drop and accept counter width
`define UC_CNT_W 8

//////////////////////////////
// buffer and reset values
//////////////////////////////

// c2h buffer is 4 KiB
`define UC_BUF_SHIFT 12
// 128 byte default transfer
`define UC_LEN_RST 128
`define UC_NUM_PKT_RST 1
`define UC_QID_RST 1

`endif

//--- rtl/user_ctrl_pkg.sv
// shared types of the C2H credit manager, compiled ahead of all RTL and referenced by scoped name
`include "user_ctrl_params.svh"

package user_ctrl_pkg;

   // one axi-lite data or address word
   typedef logic [`UC_AXIL_W-1:0] axil_word_t;
   // queue index into the credit table
   typedef logic [`UC_QID_W-1:0]  qid_t;
   // credit count
   typedef logic [`UC_CRD_W-1:0]  credit_t;
   // byte length
   typedef logic [`UC_LEN_W-1:0]  len_t;
   // packet count
   typedef logic [`UC_PKT_W-1:0]  pkt_cnt_t;

   // register map offsets
   typedef enum logic [`UC_AXIL_W-1:0] {
      REG_QID        = 'h00,
      REG_LEN        = 'h04,
      REG_C2H_CTRL   = 'h08,
      REG_GRANT_STS  = 'h18,
      REG_NUM_PKT    = 'h20,
      REG_SCRATCH0   = 'h60,
      REG_SCRATCH1   = 'h64,
      REG_DROP_CNT   = 'h88,
      REG_ACCEPT_CNT = 'h8C
   } reg_addr_e;

   // credit grant states
   typedef enum logic [1:0] {CRDT_IDLE, CRDT_TFR, CRDT_END} crdt_state_e;

endpackage

//--- rtl/user_ctrl_top.sv
// top of the C2H credit manager joining register file, credit table and grant FSM
`timescale 1ns/1ps

module user_ctrl_top (
   input  logic                       axi_aclk,
   input  logic                       axi_aresetn,
   input  user_ctrl_pkg::axil_word_t  m_axil_awaddr,
   input  logic                       m_axil_wvalid,
   input  logic                       m_axil_wready,
   input  user_ctrl_pkg::axil_word_t  m_axil_wdata,
   input  user_ctrl_pkg::axil_word_t  m_axil_araddr,
   input  logic                       axis_c2h_drop,
   input  logic                       axis_c2h_drop_valid,
   input  logic                       tm_dsc_sts_vld,
   input  logic                       tm_dsc_sts_qen,
   input  logic                       tm_dsc_sts_qinv,
   input  logic                       tm_dsc_sts_mm,
   input  logic                       tm_dsc_sts_dir,
   input  user_ctrl_pkg::qid_t        tm_dsc_sts_qid,
   input  user_ctrl_pkg::credit_t     tm_dsc_sts_avl,
   output user_ctrl_pkg::axil_word_t  m_axil_rdata,
   output logic                       st_loopback,
   output user_ctrl_pkg::qid_t        c2h_st_qid,
   output user_ctrl_pkg::len_t        c2h_st_len,
   output user_ctrl_pkg::pkt_cnt_t    c2h_num_pkt,
   output user_ctrl_pkg::credit_t     credit_out,
   output user_ctrl_pkg::credit_t     credit_needed,
   output user_ctrl_pkg::credit_t     credit_perpkt_in,
   output logic                       credit_updt,
   output logic                       tm_dsc_sts_rdy
);

   // start and status between registers and grant FSM
   logic                   start_pls;
   logic                   grant_busy;
   user_ctrl_pkg::credit_t credit_sent;
   // availability of the active queue
   user_ctrl_pkg::credit_t crd_avail;
   logic                   crd_added;

   uc_reg_file uc_reg_file_inst (
      .axi_aclk, .axi_aresetn, .m_axil_awaddr, .m_axil_wvalid, .m_axil_wready,
      .m_axil_wdata, .m_axil_araddr, .axis_c2h_drop, .axis_c2h_drop_valid,
      .grant_busy, .credit_sent, .m_axil_rdata, .st_loopback, .c2h_st_qid,
      .c2h_st_len, .c2h_num_pkt, .start_pls
   );

   uc_credit_table uc_credit_table_inst (
      .axi_aclk, .axi_aresetn, .tm_dsc_sts_vld, .tm_dsc_sts_qen, .tm_dsc_sts_qinv,
      .tm_dsc_sts_mm, .tm_dsc_sts_dir, .tm_dsc_sts_qid, .tm_dsc_sts_avl, .c2h_st_qid,
      .credit_updt, .credit_out, .tm_dsc_sts_rdy, .crd_avail, .crd_added
   );

   uc_credit_grant uc_credit_grant_inst (
      .axi_aclk, .axi_aresetn, .start_pls, .c2h_st_len, .c2h_num_pkt, .crd_avail,
      .crd_added, .credit_needed, .credit_perpkt_in, .credit_out, .credit_updt,
      .credit_sent, .grant_busy
   );

endmodule

//--- run_sim.sh
#!/bin/sh
# build the C2H credit manager testbench with Verilator and run it

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert -Wno-fatal \
   -f user_ctrl.f --top-module user_ctrl_tb \
   --Mdir "$OBJ" -o user_ctrl_sim
status=$?
if [ $status -ne 0 ]; then
   echo "build failed with status $status"
   exit 1
fi

./"$OBJ"/user_ctrl_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -q "All checks passed" "$LOG"; then
   exit 0
else
   echo "pass message not found in $LOG"
   exit 1
fi

//--- tests/user_ctrl_asserts.sv
// concurrent checks on the credit protocol, bound into the grant FSM and the credit table
`timescale 1ns/1ps

module user_ctrl_asserts (
   input  logic                       axi_aclk,
   input  logic                       axi_aresetn,
   input  logic                       grant_idle,
   input  logic                       credit_updt,
   input  user_ctrl_pkg::credit_t     credit_out,
   input  user_ctrl_pkg::credit_t     crd_avail,
   input  logic                       upd_pend,
   input  logic                       hold_vld
);

   // no grant pulse while the FSM sits idle
   a_updt_not_idle: assert property (@(posedge axi_aclk) disable iff (!axi_aresetn)
      credit_updt |-> !grant_idle) else $error("credit_updt seen in idle state");

   // a grant always carries credits
   a_out_nonzero: assert property (@(posedge axi_aclk) disable iff (!axi_aresetn)
      credit_updt |-> (credit_out != '0)) else $error("credit_out zero on credit_updt");

   // grant sized from the availability of the cycle before
   a_out_le_avail: assert property (@(posedge axi_aclk) disable iff (!axi_aresetn)
      credit_updt |-> (credit_out <= $past(crd_avail)))
      else $error("credit_out larger than crd_avail");

   // back-pressure keeps the hold slot single, no new update lands on a held one
   a_hold_no_overrun: assert property (@(posedge axi_aclk) disable iff (!axi_aresetn)
      hold_vld |-> !upd_pend) else $error("update accepted while the hold slot was full");

endmodule

bind uc_credit_grant user_ctrl_asserts grant_asserts_inst (
   .axi_aclk(axi_aclk), .axi_aresetn(axi_aresetn),
   .grant_idle(crdt_state == user_ctrl_pkg::CRDT_IDLE),
   .credit_updt(credit_updt), .credit_out(credit_out), .crd_avail(crd_avail),
   .upd_pend(1'b0), .hold_vld(1'b0)
);

bind uc_credit_table user_ctrl_asserts table_asserts_inst (
   .axi_aclk(axi_aclk), .axi_aresetn(axi_aresetn), .grant_idle(1'b0),
   .credit_updt(credit_updt), .credit_out(credit_out), .crd_avail(crd_avail),
   .upd_pend(upd_d1), .hold_vld(hold_vld)
);

//--- tests/user_ctrl_tb.sv
// testbench of the C2H credit manager, drives register writes and traffic-manager updates
`timescale 1ns/1ps
`include "user_ctrl_params.svh"

module user_ctrl_tb;

   localparam int NUM_ROWS    = 5;
   localparam int CYCLE_LIMIT = 200 * (NUM_ROWS + 1);
   localparam int COLLIDE_AVL = 2;
   localparam int STALE_AVL   = 50;

   logic axi_aclk;
   logic axi_aresetn;
   user_ctrl_pkg::axil_word_t m_axil_awaddr;
   logic m_axil_wvalid;
   logic m_axil_wready;
   user_ctrl_pkg::axil_word_t m_axil_wdata;
   user_ctrl_pkg::axil_word_t m_axil_araddr;
   logic axis_c2h_drop;
   logic axis_c2h_drop_valid;
   logic tm_dsc_sts_vld;
   logic tm_dsc_sts_qen;
   logic tm_dsc_sts_qinv;
   logic tm_dsc_sts_mm;
   logic tm_dsc_sts_dir;
   user_ctrl_pkg::qid_t tm_dsc_sts_qid;
   user_ctrl_pkg::credit_t tm_dsc_sts_avl;
   user_ctrl_pkg::axil_word_t m_axil_rdata;
   logic st_loopback;
   user_ctrl_pkg::qid_t c2h_st_qid;
   user_ctrl_pkg::len_t c2h_st_len;
   user_ctrl_pkg::pkt_cnt_t c2h_num_pkt;
   user_ctrl_pkg::credit_t credit_out;
   user_ctrl_pkg::credit_t credit_needed;
   user_ctrl_pkg::credit_t credit_perpkt_in;
   logic credit_updt;
   logic tm_dsc_sts_rdy;

   //////////////////////////////
   // stimulus table
   //////////////////////////////

   // pre is credits before start, step/nstep are the TM additions after start
   string row_name  [NUM_ROWS] = '{"full_small", "full_big", "partial", "filtered", "collide"};
   int    row_qid   [NUM_ROWS] = '{2, 3, 5, 7, 9};
   int    row_len   [NUM_ROWS] = '{128, 10000, 8192, 4097, 4096};
   int    row_pkt   [NUM_ROWS] = '{4, 2, 5, 3, 5};
   int    row_pre   [NUM_ROWS] = '{6, 6, 0, 0, 2};
   int    row_step  [NUM_ROWS] = '{0, 0, 3, 2, 2};
   int    row_nstep [NUM_ROWS] = '{0, 0, 4, 3, 1};
   bit    row_filt  [NUM_ROWS] = '{0, 0, 0, 1, 0};
   bit    row_coll  [NUM_ROWS] = '{0, 0, 0, 0, 1};

   int          error_cnt;
   int          check_cnt;
   int          cycle_cnt;
   logic [31:0] lfsr_state;
   // grant bookkeeping of the running transfer
   int          exp_need;
   int          grant_sum;
   int          grant_cnt;
   int          last_out;
   int          rdy_low_cnt;

   user_ctrl_top user_ctrl_top_inst (.*);

   initial begin
      axi_aclk = 1'b0;
      forever #4 axi_aclk = ~axi_aclk;
   end

   // galois form, taps 32,22,2,1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      lfsr_next = s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
   endfunction

   function int take_bits(input int n);
      int v;
      v = 0;
      for (int i = 0; i < n; i++) begin
         lfsr_state = lfsr_next(lfsr_state);
         v = (v << 1) | int'(lfsr_state[0]);
      end
      return v;
   endfunction

   task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
      check_cnt++;
      if (exp !== act) begin
         error_cnt++;
         $display("Error %s: expected 0x%0h, actual 0x%0h", name, exp, act);
      end
   endtask

   // all bus tasks start and end on a falling edge
   task automatic idle(input int n);
      repeat (n) @(negedge axi_aclk);
   endtask

   task automatic reg_write(input logic [31:0] addr, input logic [31:0] data);
      m_axil_awaddr = addr;
      m_axil_wdata  = data;
      m_axil_wvalid = 1'b1;
      m_axil_wready = 1'b1;
      @(negedge axi_aclk);
      m_axil_wvalid = 1'b0;
      m_axil_wready = 1'b0;
   endtask

   // rdata is combinational, sample inside the low phase
   task automatic reg_read(input logic [31:0] addr, output logic [31:0] data);
      m_axil_araddr = addr;
      #1;
      data = m_axil_rdata;
      @(negedge axi_aclk);
   endtask

   task automatic tm_send(input int qid, input int avl, input logic qen, input logic qinv,
                          input logic mm, input logic dir);
      tm_dsc_sts_qid  = user_ctrl_pkg::qid_t'(qid);
      tm_dsc_sts_avl  = user_ctrl_pkg::credit_t'(avl);
      tm_dsc_sts_qen  = qen;
      tm_dsc_sts_qinv = qinv;
      tm_dsc_sts_mm   = mm;
      tm_dsc_sts_dir  = dir;
      tm_dsc_sts_vld  = 1'b1;
      // hold the beat until the table takes it
      while (!tm_dsc_sts_rdy) @(negedge axi_aclk);
      @(negedge axi_aclk);
      tm_dsc_sts_vld = 1'b0;
   endtask

   // grant monitor, one credit_updt pulse per cycle
   always @(negedge axi_aclk) begin
      if (axi_aresetn) begin
         if (!tm_dsc_sts_rdy) rdy_low_cnt++;
         if (credit_updt) begin
            check("grant nonzero", 1, credit_out != '0);
            check("grant within remainder", 1, int'(credit_out) <= exp_need - grant_sum);
            grant_sum += int'(credit_out);
            grant_cnt++;
            last_out = int'(credit_out);
         end
      end
   end

   task automatic register_test();
      logic [31:0] rd;
      reg_read(user_ctrl_pkg::REG_QID, rd);
      check("qid reset", 1, rd);
      reg_read(user_ctrl_pkg::REG_LEN, rd);
      check("len reset", 128, rd);
      reg_read(user_ctrl_pkg::REG_NUM_PKT, rd);
      check("num_pkt reset", 1, rd);
      reg_write(user_ctrl_pkg::REG_QID, 32'h2a);
      reg_write(user_ctrl_pkg::REG_LEN, 32'h1234);
      reg_write(user_ctrl_pkg::REG_NUM_PKT, 32'h155);
      reg_write(user_ctrl_pkg::REG_SCRATCH0, 32'hdead_beef);
      reg_write(user_ctrl_pkg::REG_SCRATCH1, 32'h0bad_f00d);
      reg_read(user_ctrl_pkg::REG_QID, rd);
      check("qid readback", 32'h2a, rd);
      reg_read(user_ctrl_pkg::REG_LEN, rd);
      check("len readback", 32'h1234, rd);
      reg_read(user_ctrl_pkg::REG_NUM_PKT, rd);
      check("num_pkt readback", 32'h155, rd);
      // register values also leave the block as ports
      check("qid port", 32'h2a, c2h_st_qid);
      check("len port", 32'h1234, c2h_st_len);
      check("num_pkt port", 32'h155, c2h_num_pkt);
      reg_read(user_ctrl_pkg::REG_SCRATCH0, rd);
      check("scratch0 readback", 32'hdead_beef, rd);
      reg_read(user_ctrl_pkg::REG_SCRATCH1, rd);
      check("scratch1 readback", 32'h0bad_f00d, rd);
      reg_read(32'h40, rd);
      check("unmapped read", 0, rd);
      // loopback only, no start
      reg_write(user_ctrl_pkg::REG_C2H_CTRL, 32'h1);
      check("loopback set", 1, st_loopback);
      reg_read(user_ctrl_pkg::REG_C2H_CTRL, rd);
      check("ctrl readback", 1, rd);
   endtask

   task automatic run_row(input int r);
      int perpkt;
      int need;
      int nd;
      int na;
      int v;
      int d;
      logic [31:0] rd;
      string nm;
      nm = row_name[r];
      // ceiling of len over the 4 KiB buffer, at least one
      perpkt = (row_len[r] <= (1 << `UC_BUF_SHIFT)) ? 1 :
               (row_len[r] + (1 << `UC_BUF_SHIFT) - 1) / (1 << `UC_BUF_SHIFT);
      need = perpkt * row_pkt[r];
      // stale credits on the queue, the qinv right after has to wipe them
      tm_send(row_qid[r], STALE_AVL, 1'b1, 1'b0, 1'b0, 1'b1);
      tm_send(row_qid[r], 0, 1'b0, 1'b1, 1'b0, 1'b1);
      reg_write(user_ctrl_pkg::REG_QID, row_qid[r]);
      reg_write(user_ctrl_pkg::REG_LEN, row_len[r]);
      reg_write(user_ctrl_pkg::REG_NUM_PKT, row_pkt[r]);
      if (row_pre[r] > 0) begin
         tm_send(row_qid[r], row_pre[r], 1'b1, 1'b0, 1'b0, 1'b1);
         idle(3);
      end
      exp_need    = need;
      grant_sum   = 0;
      grant_cnt   = 0;
      last_out    = 0;
      rdy_low_cnt = 0;
      reg_write(user_ctrl_pkg::REG_C2H_CTRL, 32'h2);
      // demand registered one cycle after the start pulse
      idle(1);
      check({nm, " credit_needed"}, need, credit_needed);
      check({nm, " credit_perpkt_in"}, perpkt, credit_perpkt_in);
      // lands in the same cycle as the first grant
      if (row_coll[r]) tm_send(row_qid[r], COLLIDE_AVL, 1'b1, 1'b0, 1'b0, 1'b1);
      reg_read(user_ctrl_pkg::REG_C2H_CTRL, rd);
      check({nm, " start self clear"}, 0, rd);
      check({nm, " loopback off"}, 0, st_loopback);
      reg_read(user_ctrl_pkg::REG_DROP_CNT, rd);
      check({nm, " drop cleared"}, 0, rd);
      reg_read(user_ctrl_pkg::REG_ACCEPT_CNT, rd);
      check({nm, " accept cleared"}, 0, rd);
      // an invalidated queue has nothing to give until new avl arrives
      if (row_pre[r] == 0) begin
         check({nm, " no grant before avl"}, 0, grant_cnt);
      end
      if (row_filt[r]) begin
         tm_send(row_qid[r], 50, 1'b1, 1'b0, 1'b1, 1'b1);
         tm_send(row_qid[r], 50, 1'b1, 1'b0, 1'b0, 1'b0);
         idle(6);
         check({nm, " no grant from filtered"}, 0, grant_cnt);
         reg_read(user_ctrl_pkg::REG_GRANT_STS, rd);
         check({nm, " busy waiting"}, 32'h8000_0000, rd);
      end
      for (int i = 0; i < row_nstep[r]; i++) begin
         idle(4 + take_bits(3));
         tm_send(row_qid[r], row_step[r], 1'b1, 1'b0, 1'b0, 1'b1);
      end
      while (grant_sum < need) idle(1);
      idle(3);
      reg_read(user_ctrl_pkg::REG_GRANT_STS, rd);
      check({nm, " grant status idle"}, 0, rd);
      check({nm, " grant sum"}, need, grant_sum);
      if (row_pre[r] >= need) begin
         check({nm, " single grant"}, 1, grant_cnt);
         check({nm, " full credit_out"}, need, last_out);
      end
      check({nm, " rdy low cycles"}, row_coll[r] ? 1 : 0, rdy_low_cnt);
      // random drop and accept beats
      nd = 0;
      na = 0;
      repeat (8) begin
         v = take_bits(1);
         d = take_bits(1);
         axis_c2h_drop_valid = v[0];
         axis_c2h_drop       = d[0];
         if (v != 0) begin
            if (d != 0) nd++;
            else na++;
         end
         idle(1);
      end
      axis_c2h_drop_valid = 1'b0;
      reg_read(user_ctrl_pkg::REG_DROP_CNT, rd);
      check({nm, " drop count"}, nd, rd);
      reg_read(user_ctrl_pkg::REG_ACCEPT_CNT, rd);
      check({nm, " accept count"}, na, rd);
   endtask

   //////////////////////////////
   // timeout
   //////////////////////////////

   initial begin
      cycle_cnt = 0;
      while (cycle_cnt < CYCLE_LIMIT) begin
         @(posedge axi_aclk);
         cycle_cnt++;
      end
      $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("Checks failed");
      $finish;
   end

   initial begin
      error_cnt = 0;
      check_cnt = 0;
      exp_need = 0;
      grant_sum = 0;
      grant_cnt = 0;
      last_out = 0;
      rdy_low_cnt = 0;
      lfsr_state = 32'h49d3_d7a1;
      axi_aresetn = 1'b0;
      m_axil_awaddr = '0;
      m_axil_wvalid = 1'b0;
      m_axil_wready = 1'b0;
      m_axil_wdata = '0;
      m_axil_araddr = '0;
      axis_c2h_drop = 1'b0;
      axis_c2h_drop_valid = 1'b0;
      tm_dsc_sts_vld = 1'b0;
      tm_dsc_sts_qen = 1'b0;
      tm_dsc_sts_qinv = 1'b0;
      tm_dsc_sts_mm = 1'b0;
      tm_dsc_sts_dir = 1'b0;
      tm_dsc_sts_qid = '0;
      tm_dsc_sts_avl = '0;
      repeat (3) @(posedge axi_aclk);
      @(negedge axi_aclk);
      axi_aresetn = 1'b1;
      check("rdy after reset", 1, tm_dsc_sts_rdy);
      check("updt after reset", 0, credit_updt);
      check("loopback after reset", 0, st_loopback);
      register_test();
      for (int r = 0; r < NUM_ROWS; r++) begin
         run_row(r);
      end
      idle(2);
      $display("checks: %0d, errors: %0d", check_cnt, error_cnt);
      if (error_cnt == 0) begin
         $display("All checks passed");
      end else begin
         $display("Checks failed");
      end
      $finish;
   end

endmodule

//--- user_ctrl.f
+incdir+rtl
rtl/user_ctrl_pkg.sv
rtl/uc_reg_file.sv
rtl/uc_credit_table.sv
rtl/uc_credit_grant.sv
rtl/user_ctrl_top.sv
tests/user_ctrl_asserts.sv
tests/user_ctrl_tb.sv
